//--- src.f
+incdir+hdl
+incdir+verif
hdl/decode_pkg.sv
hdl/uop_if.sv
hdl/pipe_ctrl.sv
hdl/uop_decoder.sv
hdl/imm_builder.sv
hdl/uop_reg.sv
hdl/decode_top.sv
verif/tb_decode.sv

//--- run.sh
#!/bin/sh
# compile and run the decode stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_decode -f src.f -o tb_decode
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_decode 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

//--- verif/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

localparam logic [1:0] S_IDLE = 2'd0;
localparam logic [1:0] S_WAIT = 2'd1;
localparam logic [1:0] S_SEND = 2'd2;

// expected register contents after the latest capture
logic [3:0]  exp_cls;       // ls, alu, jmp, ldpc
logic [2:0]  exp_vld;       // r1, r2, r3
logic [4:0]  exp_r1_idx, exp_r2_idx, exp_rd_idx;
logic [31:0] exp_r2_val, exp_r3_val, exp_pc, exp_next_pc;
logic [3:0]  exp_ls;        // is_load, ld_size, ld_extend
logic [9:0]  exp_alu;       // add sub xor or and slt sltu sll srl sra
logic [6:0]  exp_jmp;       // jalr jal unsigned eq neq lt ge
logic        exp_need_pc;

function automatic logic [1:0] next_state(input logic [1:0] s, input logic strobe,
                                          input logic prv, input logic nxt);
    if (strobe) begin
        return prv ? S_SEND : S_WAIT;
    end
    if (s == S_WAIT && prv) begin
        return S_SEND;
    end
    if (s == S_SEND && nxt) begin
        return prv ? S_SEND : S_WAIT;
    end
    return s;
endfunction

// {ready_to_rcv, ready_to_send, capture}
function automatic logic [2:0] handshake_levels(input logic [1:0] s, input logic irq,
                                                input logic nxt);
    logic send;
    send = (s == S_SEND) && nxt && !irq;
    return {(s == S_WAIT) || (send && nxt), send, (s == S_SEND) && nxt};
endfunction

function automatic logic [9:0] alu_flags(input logic [2:0] f3, input logic b30,
                                         input logic reg_op);
    case (f3)
        `F3_ADD:  return (reg_op && b30) ? 10'b01_0000_0000 : 10'b10_0000_0000;
        `F3_XOR:  return 10'b00_1000_0000;
        `F3_OR:   return 10'b00_0100_0000;
        `F3_AND:  return 10'b00_0010_0000;
        `F3_SLT:  return 10'b00_0001_0000;
        `F3_SLTU: return 10'b00_0000_1000;
        `F3_SLL:  return 10'b00_0000_0100;
        default:  return b30 ? 10'b00_0000_0001 : 10'b00_0000_0010;
    endcase
endfunction

task automatic predict_decode(input inst_word_t w, input logic [31:0] cur_pc,
                              input logic [31:0] nxt_pc);
    logic [31:0] b;
    logic [2:0]  f3;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    b = w;
    f3 = w.r.funct3;
    // standard rv32i immediate layouts, taken from raw bit positions
    imm_i = {{20{b[31]}}, b[31:20]};
    imm_s = {{20{b[31]}}, b[31:25], b[11:7]};
    imm_b = {{19{b[31]}}, b[31], b[7], b[30:25], b[11:8], 1'b0};
    imm_u = {b[31:12], 12'b0};
    imm_j = {{11{b[31]}}, b[31], b[19:12], b[20], b[30:21], 1'b0};
    {exp_cls, exp_vld, exp_ls, exp_alu, exp_jmp, exp_need_pc} = '0;
    {exp_r1_idx, exp_r2_idx, exp_rd_idx, exp_r2_val, exp_r3_val} = '0;
    exp_pc = cur_pc;
    exp_next_pc = nxt_pc;
    case (w.r.opcode)
        `OPC_LOAD, `OPC_STORE: begin
            exp_cls = 4'b1000;
            exp_vld = 3'b001;
            exp_r1_idx = w.r.rs1;
            exp_ls = {w.r.opcode == `OPC_LOAD, f3[1:0], f3[2]};
            if (w.r.opcode == `OPC_LOAD) begin
                exp_rd_idx = w.r.rd;
                exp_r3_val = imm_i;
            end else begin
                exp_r2_idx = w.r.rs2;
                exp_r3_val = imm_s;
            end
        end
        `OPC_OP_IMM: begin
            exp_cls = 4'b0100;
            exp_vld = 3'b010;
            exp_r1_idx = w.r.rs1;
            exp_rd_idx = w.r.rd;
            exp_r2_val = imm_i;
            exp_alu = alu_flags(f3, b[30], 1'b0);
        end
        `OPC_OP: begin
            exp_cls = 4'b0100;
            exp_r1_idx = w.r.rs1;
            exp_r2_idx = w.r.rs2;
            exp_rd_idx = w.r.rd;
            exp_alu = alu_flags(f3, b[30], 1'b1);
        end
        `OPC_LUI, `OPC_AUIPC: begin
            exp_cls = 4'b0001;
            exp_vld = 3'b010;
            exp_rd_idx = w.r.rd;
            exp_r2_val = imm_u;
            exp_need_pc = w.r.opcode == `OPC_AUIPC;
        end
        `OPC_BRANCH: begin
            exp_cls = 4'b0010;
            exp_vld = 3'b001;
            exp_r1_idx = w.r.rs1;
            exp_r2_idx = w.r.rs2;
            exp_rd_idx = w.r.rd;
            exp_r3_val = imm_b;
            exp_jmp = {2'b00, f3[1], f3 == 3'd0, f3 == 3'd1,
                       f3 == 3'd4 || f3 == 3'd6, f3 == 3'd5 || f3 == 3'd7};
        end
        `OPC_JALR: begin
            exp_cls = 4'b0010;
            exp_vld = 3'b010;
            exp_r1_idx = w.r.rs1;
            exp_rd_idx = w.r.rd;
            exp_r2_val = imm_i;
            exp_jmp = 7'b100_0000;
        end
        `OPC_JAL: begin
            exp_cls = 4'b0010;
            // r1 is a valid zero base
            exp_vld = 3'b110;
            exp_rd_idx = w.r.rd;
            exp_r2_val = imm_j;
            exp_jmp = 7'b010_0000;
        end
        default: ;
    endcase
endtask

`endif

//--- verif/tb_decode.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module tb_decode import decode_pkg::*; ();
    localparam int N_CYCLES   = 3000;
    localparam int TIMEOUT_NS = (N_CYCLES + 8 + 200) * 4;

    logic                clk;
    logic                rst, start, interrupt_start, prev_ready_to_send, next_ready_to_rcv;
    logic [`XLEN-1:0]    fetch_data, fetch_pc, fetch_next_pc;
    logic                ready_to_rcv, ready_to_send;
    logic                r1_valid, r2_valid, r3_valid, rd_valid;
    logic [`REG_IDX-1:0] r1_idx, r2_idx, r3_idx, rd_idx;
    logic [`XLEN-1:0]    r1_val, r2_val, r3_val;
    logic                ls_use, is_load, ld_extend;
    logic [1:0]          ld_size;
    logic                alu_use, is_add, is_sub, is_xor, is_or, is_and;
    logic                is_slt, is_sltu, is_sll, is_srl, is_sra;
    logic                jmp_use, is_jalr, is_jal, jump_unsigned;
    logic                is_eq, is_neq, is_lt, is_ge;
    logic                ldpc_use, need_pc;
    logic [`XLEN-1:0]    pc, next_pc;

    int         n_errors;
    int         n_checks;
    int         n_capt;
    logic [1:0] st;
    logic       have_exp;

    `include "decode_model.svh"

    decode_top i_decode_top (.*);

    always #2 clk = ~clk;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // called on the falling edge, all outputs settled
    task automatic verify_outputs();
        logic [2:0] hs;
        hs = handshake_levels(st, interrupt_start, next_ready_to_rcv);
        compare_field("ready_to_rcv", 32'(ready_to_rcv), 32'(hs[2]));
        compare_field("ready_to_send", 32'(ready_to_send), 32'(hs[1]));
        compare_field("{ls_use,alu_use,jmp_use,ldpc_use}",
                      32'({ls_use, alu_use, jmp_use, ldpc_use}), 32'(exp_cls));
        compare_field("{r1_valid,r2_valid,r3_valid}",
                      32'({r1_valid, r2_valid, r3_valid}), 32'(exp_vld));
        if (have_exp) begin
            compare_field("rd_valid", 32'(rd_valid), 32'd0);
            compare_field("r1_idx", 32'(r1_idx), 32'(exp_r1_idx));
            compare_field("r2_idx", 32'(r2_idx), 32'(exp_r2_idx));
            compare_field("r3_idx", 32'(r3_idx), 32'd0);
            compare_field("rd_idx", 32'(rd_idx), 32'(exp_rd_idx));
            compare_field("r1_val", r1_val, 32'd0);
            compare_field("r2_val", r2_val, exp_r2_val);
            compare_field("r3_val", r3_val, exp_r3_val);
            compare_field("{is_load,ld_size,ld_extend}",
                          32'({is_load, ld_size, ld_extend}), 32'(exp_ls));
            compare_field("is_add/sub/xor/or/and/slt/sltu/sll/srl/sra",
                          32'({is_add, is_sub, is_xor, is_or, is_and, is_slt, is_sltu,
                               is_sll, is_srl, is_sra}), 32'(exp_alu));
            compare_field("is_jalr/jal/jump_unsigned/eq/neq/lt/ge",
                          32'({is_jalr, is_jal, jump_unsigned, is_eq, is_neq, is_lt,
                               is_ge}), 32'(exp_jmp));
            compare_field("need_pc", 32'(need_pc), 32'(exp_need_pc));
            compare_field("pc", pc, exp_pc);
            compare_field("next_pc", next_pc, exp_next_pc);
        end
    endtask

    task automatic drive_inputs(input bit strobes_on);
        logic [31:0] r;
        logic [6:0]  opc;
        r = $urandom;
        case ($urandom % 10)
            0: opc = `OPC_LOAD;
            1: opc = `OPC_STORE;
            2: opc = `OPC_OP_IMM;
            3: opc = `OPC_OP;
            4: opc = `OPC_LUI;
            5: opc = `OPC_AUIPC;
            6: opc = `OPC_BRANCH;
            7: opc = `OPC_JALR;
            8: opc = `OPC_JAL;
            // random low bits, nearly always illegal
            default: opc = r[6:0];
        endcase
        fetch_data = {r[31:7], opc};
        fetch_pc = $urandom & 32'hffff_fffc;
        fetch_next_pc = fetch_pc + 32'd4;
        prev_ready_to_send = ($urandom % 3) != 0;
        next_ready_to_rcv = ($urandom % 4) != 0;
        start = strobes_on && (($urandom % 40) == 0);
        interrupt_start = strobes_on && (($urandom % 60) == 0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [2:0] hs;
        void'($urandom(99130));
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        interrupt_start = 1'b0;
        prev_ready_to_send = 1'b0;
        next_ready_to_rcv = 1'b0;
        fetch_data = '0;
        fetch_pc = '0;
        fetch_next_pc = '0;
        n_errors = 0;
        n_checks = 0;
        n_capt = 0;
        st = S_IDLE;
        have_exp = 1'b0;
        exp_cls = '0;
        exp_vld = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            @(negedge clk);
            verify_outputs();
            // no strobes early on so the idle levels get seen
            drive_inputs(cyc >= 20);
            hs = handshake_levels(st, interrupt_start, next_ready_to_rcv);
            if (hs[0]) begin
                predict_decode(fetch_data, fetch_pc, fetch_next_pc);
                have_exp = 1'b1;
                n_capt++;
            end
            st = next_state(st, start || interrupt_start, prev_ready_to_send,
                            next_ready_to_rcv);
        end
        @(negedge clk);
        verify_outputs();
        if (n_capt < 500) begin
            n_errors++;
            $display("only %0d captures happened, too few words went through", n_capt);
        end
        $display("checks: %0d  captures: %0d  errors: %0d", n_checks, n_capt, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- hdl/decode_top.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module decode_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                interrupt_start,
    input  logic                prev_ready_to_send,
    input  logic                next_ready_to_rcv,
    input  logic [`XLEN-1:0]    fetch_data,
    input  logic [`XLEN-1:0]    fetch_pc,
    input  logic [`XLEN-1:0]    fetch_next_pc,
    output logic                ready_to_rcv,
    output logic                ready_to_send,
    output logic                r1_valid, r2_valid, r3_valid, rd_valid,
    output logic [`REG_IDX-1:0] r1_idx, r2_idx, r3_idx, rd_idx,
    output logic [`XLEN-1:0]    r1_val, r2_val, r3_val,
    output logic                ls_use, is_load,
    output logic [1:0]          ld_size,
    output logic                ld_extend,
    output logic                alu_use, is_add, is_sub, is_xor, is_or, is_and,
    output logic                is_slt, is_sltu, is_sll, is_srl, is_sra,
    output logic                jmp_use, is_jalr, is_jal, jump_unsigned,
    output logic                is_eq, is_neq, is_lt, is_ge,
    output logic                ldpc_use, need_pc,
    output logic [`XLEN-1:0]    pc, next_pc
);
    logic capture;

    uop_if i_uop_if ();

    pipe_ctrl i_pipe_ctrl (
        .clk                (clk),
        .rst                (rst),
        .start              (start),
        .interrupt_start    (interrupt_start),
        .prev_ready_to_send (prev_ready_to_send),
        .next_ready_to_rcv  (next_ready_to_rcv),
        .ready_to_rcv       (ready_to_rcv),
        .ready_to_send      (ready_to_send),
        .capture            (capture)
    );

    // decode and immediate are combinational off the fetch word
    uop_decoder i_uop_decoder (
        .fetch_data (fetch_data),
        .u          (i_uop_if.dec)
    );

    imm_builder i_imm_builder (
        .fetch_data (fetch_data),
        .u          (i_uop_if.imm)
    );

    // output ports share their names with the register outputs
    uop_reg i_uop_reg (
        .u       (i_uop_if.regs),
        .capture (capture),
        .*
    );

endmodule

//--- hdl/uop_reg.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module uop_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                capture,
    input  logic [`XLEN-1:0]    fetch_pc,
    input  logic [`XLEN-1:0]    fetch_next_pc,
    uop_if.regs                 u,
    output logic                r1_valid, r2_valid, r3_valid, rd_valid,
    output logic [`REG_IDX-1:0] r1_idx, r2_idx, r3_idx, rd_idx,
    output logic [`XLEN-1:0]    r1_val, r2_val, r3_val,
    output logic                ls_use, is_load,
    output logic [1:0]          ld_size,
    output logic                ld_extend,
    output logic                alu_use, is_add, is_sub, is_xor, is_or, is_and,
    output logic                is_slt, is_sltu, is_sll, is_srl, is_sra,
    output logic                jmp_use, is_jalr, is_jal, jump_unsigned,
    output logic                is_eq, is_neq, is_lt, is_ge,
    output logic                ldpc_use, need_pc,
    output logic [`XLEN-1:0]    pc, next_pc
);
    // slot 1 only ever holds jal's zero base, dest is marked valid downstream
    assign r1_val   = '0;
    assign rd_valid = 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            {r1_valid, r2_valid, r3_valid} <= 3'b000;
            {ls_use, alu_use, jmp_use, ldpc_use} <= 4'b0000;
        end else if (capture) begin
            r1_valid <= u.r1_valid;
            r2_valid <= u.r2_valid;
            r3_valid <= u.r3_valid;
            ls_use   <= u.ls_use;
            alu_use  <= u.alu_use;
            jmp_use  <= u.jmp_use;
            ldpc_use <= u.ldpc_use;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            r1_idx    <= u.r1_idx;
            r2_idx    <= u.r2_idx;
            r3_idx    <= u.r3_idx;
            rd_idx    <= u.rd_idx;
            r2_val    <= (u.imm_slot == `IMM_TO_R2) ? u.imm_val : '0;
            r3_val    <= (u.imm_slot == `IMM_TO_R3) ? u.imm_val : '0;
            is_load   <= u.is_load;
            ld_size   <= u.ld_size;
            ld_extend <= u.ld_extend;
            is_add    <= u.is_add;
            is_sub    <= u.is_sub;
            is_xor    <= u.is_xor;
            is_or     <= u.is_or;
            is_and    <= u.is_and;
            is_slt    <= u.is_slt;
            is_sltu   <= u.is_sltu;
            is_sll    <= u.is_sll;
            is_srl    <= u.is_srl;
            is_sra    <= u.is_sra;
            is_jalr   <= u.is_jalr;
            is_jal    <= u.is_jal;
            is_eq     <= u.is_eq;
            is_neq    <= u.is_neq;
            is_lt     <= u.is_lt;
            is_ge     <= u.is_ge;
            jump_unsigned <= u.jump_unsigned;
            need_pc   <= u.need_pc;
            pc        <= fetch_pc;
            next_pc   <= fetch_next_pc;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        capture |=> $onehot0({ls_use, alu_use, jmp_use, ldpc_use}));

endmodule

//--- hdl/imm_builder.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module imm_builder import decode_pkg::*; (
    input  inst_word_t fetch_data,
    uop_if.imm         u
);
    i_fmt_t fi;
    s_fmt_t fs;
    b_fmt_t fb;
    u_fmt_t fu;
    j_fmt_t fj;

    assign fi = fetch_data.i;
    assign fs = fetch_data.s;
    assign fb = fetch_data.b;
    assign fu = fetch_data.u;
    assign fj = fetch_data.j;

    always_comb begin
        case (u.imm_fmt)
            `IMM_I: u.imm_val = {{20{fi.imm_11_0[11]}}, fi.imm_11_0};
            `IMM_S: u.imm_val = {{20{fs.imm_11_5[6]}}, fs.imm_11_5, fs.imm_4_0};
            // b and j offsets are halfword aligned
            `IMM_B: u.imm_val = {{19{fb.imm_12}}, fb.imm_12, fb.imm_11, fb.imm_10_5,
                                 fb.imm_4_1, 1'b0};
            `IMM_U: u.imm_val = {fu.imm_31_12, 12'b0};
            `IMM_J: u.imm_val = {{11{fj.imm_20}}, fj.imm_20, fj.imm_19_12, fj.imm_11,
                                 fj.imm_10_1, 1'b0};
            default: u.imm_val = '0;
        endcase
    end

endmodule

//--- hdl/uop_decoder.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

module uop_decoder import decode_pkg::*; (
    input  inst_word_t fetch_data,
    uop_if.dec         u
);
    logic [6:0]          opc;
    logic [2:0]          f3;
    logic                b30;
    logic [`REG_IDX-1:0] rs1;
    logic [`REG_IDX-1:0] rs2;
    logic [`REG_IDX-1:0] rd;
    logic                op_load, op_store, op_imm, op_reg, op_lui;
    logic                op_auipc, op_branch, op_jalr, op_jal;
    logic                cls_ls, cls_alu, cls_jmp, cls_ldpc;

    assign opc = fetch_data.r.opcode;
    assign f3  = fetch_data.r.funct3;
    assign b30 = fetch_data.r.funct7[5];
    assign rs1 = fetch_data.r.rs1;
    assign rs2 = fetch_data.r.rs2;
    assign rd  = fetch_data.r.rd;

    // full 7-bit compare also rejects low bits other than 11
    assign op_load   = opc == `OPC_LOAD;
    assign op_store  = opc == `OPC_STORE;
    assign op_imm    = opc == `OPC_OP_IMM;
    assign op_reg    = opc == `OPC_OP;
    assign op_lui    = opc == `OPC_LUI;
    assign op_auipc  = opc == `OPC_AUIPC;
    assign op_branch = opc == `OPC_BRANCH;
    assign op_jalr   = opc == `OPC_JALR;
    assign op_jal    = opc == `OPC_JAL;

    assign cls_ls   = op_load || op_store;
    assign cls_alu  = op_imm || op_reg;
    assign cls_jmp  = op_branch || op_jalr || op_jal;
    assign cls_ldpc = op_lui || op_auipc;

    assign u.ls_use   = cls_ls;
    assign u.alu_use  = cls_alu;
    assign u.jmp_use  = cls_jmp;
    assign u.ldpc_use = cls_ldpc;

    // slot routing
    assign u.r1_valid = op_jal;
    assign u.r2_valid = op_imm || cls_ldpc || op_jalr || op_jal;
    assign u.r3_valid = cls_ls || op_branch;
    assign u.r1_idx   = (cls_ls || cls_alu || op_branch || op_jalr) ? rs1 : '0;
    assign u.r2_idx   = (op_store || op_reg || op_branch) ? rs2 : '0;
    assign u.r3_idx   = '0;
    assign u.rd_idx   = (op_load || cls_alu || cls_ldpc || cls_jmp) ? rd : '0;

    assign u.is_load   = op_load;
    assign u.ld_size   = cls_ls ? f3[1:0] : 2'b00;
    assign u.ld_extend = cls_ls && f3[2];

    // bit 30 picks sub only for register-register ops
    assign u.is_add  = cls_alu && (f3 == `F3_ADD) && !(op_reg && b30);
    assign u.is_sub  = op_reg && (f3 == `F3_ADD) && b30;
    assign u.is_xor  = cls_alu && (f3 == `F3_XOR);
    assign u.is_or   = cls_alu && (f3 == `F3_OR);
    assign u.is_and  = cls_alu && (f3 == `F3_AND);
    assign u.is_slt  = cls_alu && (f3 == `F3_SLT);
    assign u.is_sltu = cls_alu && (f3 == `F3_SLTU);
    assign u.is_sll  = cls_alu && (f3 == `F3_SLL);
    assign u.is_srl  = cls_alu && (f3 == `F3_SR) && !b30;
    assign u.is_sra  = cls_alu && (f3 == `F3_SR) && b30;

    assign u.is_jalr       = op_jalr;
    assign u.is_jal        = op_jal;
    assign u.jump_unsigned = op_branch && f3[1];
    assign u.is_eq         = op_branch && (f3 == 3'b000);
    assign u.is_neq        = op_branch && (f3 == 3'b001);
    // blt/bltu and bge/bgeu
    assign u.is_lt         = op_branch && f3[2] && !f3[0];
    assign u.is_ge         = op_branch && f3[2] && f3[0];

    assign u.need_pc = op_auipc;

    always_comb begin
        u.imm_fmt = `IMM_NONE;
        if (op_load || op_imm || op_jalr) begin
            u.imm_fmt = `IMM_I;
        end else if (op_store) begin
            u.imm_fmt = `IMM_S;
        end else if (op_branch) begin
            u.imm_fmt = `IMM_B;
        end else if (cls_ldpc) begin
            u.imm_fmt = `IMM_U;
        end else if (op_jal) begin
            u.imm_fmt = `IMM_J;
        end
    end

    assign u.imm_slot = u.r3_valid ? `IMM_TO_R3 :
                        u.r2_valid ? `IMM_TO_R2 : `IMM_TO_NONE;

    always_comb begin
        assert ($onehot0({cls_ls, cls_alu, cls_jmp, cls_ldpc}));
    end

endmodule

//--- hdl/pipe_ctrl.sv
`timescale 1ns/100ps

module pipe_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic interrupt_start,
    input  logic prev_ready_to_send,
    input  logic next_ready_to_rcv,
    output logic ready_to_rcv,
    output logic ready_to_send,
    output logic capture
);
    localparam logic [1:0] ST_IDLE      = 2'b00;
    localparam logic [1:0] ST_WAIT_PREV = 2'b01;
    localparam logic [1:0] ST_SENDING   = 2'b10;

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else if (start || interrupt_start) begin
            state <= prev_ready_to_send ? ST_SENDING : ST_WAIT_PREV;
        end else begin
            case (state)
                ST_WAIT_PREV: begin
                    if (prev_ready_to_send) begin
                        state <= ST_SENDING;
                    end
                end
                ST_SENDING: begin
                    // item leaves, refill if upstream has one
                    if (next_ready_to_rcv) begin
                        state <= prev_ready_to_send ? ST_SENDING : ST_WAIT_PREV;
                    end
                end
                default: state <= state;
            endcase
        end
    end

    assign ready_to_send = (state == ST_SENDING) && next_ready_to_rcv && !interrupt_start;
    assign ready_to_rcv  = (state == ST_WAIT_PREV) || (ready_to_send && next_ready_to_rcv);
    // interrupt blocks the ready level only
    assign capture       = (state == ST_SENDING) && next_ready_to_rcv;

    assert property (@(posedge clk) disable iff (rst) state != 2'b11);

endmodule

//--- hdl/uop_if.sv
`timescale 1ns/100ps
`include "decode_defs.svh"

interface uop_if;
    logic                ls_use, alu_use, jmp_use, ldpc_use;
    logic                r1_valid, r2_valid, r3_valid;
    logic [`REG_IDX-1:0] r1_idx, r2_idx, r3_idx, rd_idx;
    logic                is_load;
    logic [1:0]          ld_size;
    logic                ld_extend;
    logic                is_add, is_sub, is_xor, is_or, is_and;
    logic                is_slt, is_sltu, is_sll, is_srl, is_sra;
    logic                is_jalr, is_jal, jump_unsigned;
    logic                is_eq, is_neq, is_lt, is_ge;
    logic                need_pc;
    logic [2:0]          imm_fmt;
    logic [1:0]          imm_slot;
    logic [`XLEN-1:0]    imm_val;

    modport dec (
        output ls_use, alu_use, jmp_use, ldpc_use, r1_valid, r2_valid, r3_valid,
               r1_idx, r2_idx, r3_idx, rd_idx, is_load, ld_size, ld_extend,
               is_add, is_sub, is_xor, is_or, is_and, is_slt, is_sltu, is_sll, is_srl,
               is_sra, is_jalr, is_jal, jump_unsigned, is_eq, is_neq, is_lt, is_ge,
               need_pc, imm_fmt, imm_slot
    );

    modport imm (input imm_fmt, output imm_val);

    modport regs (
        input ls_use, alu_use, jmp_use, ldpc_use, r1_valid, r2_valid, r3_valid,
              r1_idx, r2_idx, r3_idx, rd_idx, is_load, ld_size, ld_extend,
              is_add, is_sub, is_xor, is_or, is_and, is_slt, is_sltu, is_sll, is_srl,
              is_sra, is_jalr, is_jal, jump_unsigned, is_eq, is_neq, is_lt, is_ge,
              need_pc, imm_slot, imm_val
    );
endinterface

//--- hdl/decode_pkg.sv
`include "decode_defs.svh"

package decode_pkg;

    typedef struct packed {
        logic [6:0]          funct7;
        logic [`REG_IDX-1:0] rs2;
        logic [`REG_IDX-1:0] rs1;
        logic [2:0]          funct3;
        logic [`REG_IDX-1:0] rd;
        logic [6:0]          opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]         imm_11_0;
        logic [`REG_IDX-1:0] rs1;
        logic [2:0]          funct3;
        logic [`REG_IDX-1:0] rd;
        logic [6:0]          opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]          imm_11_5;
        logic [`REG_IDX-1:0] rs2;
        logic [`REG_IDX-1:0] rs1;
        logic [2:0]          funct3;
        logic [4:0]          imm_4_0;
        logic [6:0]          opcode;
    } s_fmt_t;

    // branch offset pieces scattered around rs1/rs2
    typedef struct packed {
        logic                imm_12;
        logic [5:0]          imm_10_5;
        logic [`REG_IDX-1:0] rs2;
        logic [`REG_IDX-1:0] rs1;
        logic [2:0]          funct3;
        logic [3:0]          imm_4_1;
        logic                imm_11;
        logic [6:0]          opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]         imm_31_12;
        logic [`REG_IDX-1:0] rd;
        logic [6:0]          opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                imm_20;
        logic [9:0]          imm_10_1;
        logic                imm_11;
        logic [7:0]          imm_19_12;
        logic [`REG_IDX-1:0] rd;
        logic [6:0]          opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_word_t;

endpackage

//--- hdl/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define XLEN    32
`define REG_IDX 5

// rv32i major opcodes
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_BRANCH 7'b1100011
`define OPC_JALR   7'b1100111
`define OPC_JAL    7'b1101111

`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`define IMM_NONE 3'd0
`define IMM_I    3'd1
`define IMM_S    3'd2
`define IMM_B    3'd3
`define IMM_U    3'd4
`define IMM_J    3'd5

// where the immediate lands
`define IMM_TO_NONE 2'd0
`define IMM_TO_R2   2'd1
`define IMM_TO_R3   2'd2

`endif
